//--- design/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Bus and datapath widths
  // ==================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int DIV_W        = 16;
  localparam int HEX_DIGITS   = 6;

  // ==================================================
  // Playback rate, in CLK_50M cycles per sample
  // ==================================================
  // About 22 kHz at 50 MHz
  localparam logic [DIV_W-1:0] DEFAULT_SAMPLE_DIV = 16'd2272;
  localparam logic [DIV_W-1:0] SPEED_STEP         = 16'd100;
  localparam logic [DIV_W-1:0] MIN_SAMPLE_DIV     = 16'd272;
  localparam logic [DIV_W-1:0] MAX_SAMPLE_DIV     = 16'd9972;

  // Keyboard commands, upper case ASCII
  typedef enum logic [7:0] {
    KEY_BWD     = 8'h42,
    KEY_STOP    = 8'h44,
    KEY_PLAY    = 8'h45,
    KEY_FWD     = 8'h46,
    KEY_RESTART = 8'h52
  } key_cmd_e;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    AWAIT_DATA
  } reader_state_e;

  typedef struct packed {
    logic playing;
    logic reverse;
    logic restart;
  } play_ctrl_t;

  typedef struct packed {
    logic                    read;
    logic [FLASH_ADDR_W-1:0] address;
  } flash_req_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg7_t;

endpackage

//--- design/key_command_decoder.sv
`timescale 1ns/1ps

module key_command_decoder
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  key_cmd_e   kbd_ascii,
  input  logic       kbd_valid,
  output play_ctrl_t play_ctrl
);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play_ctrl <= '0;
    end
    else
    begin
      // Restart only lives for one cycle
      play_ctrl.restart <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          KEY_PLAY:
            play_ctrl.playing <= 1'b1;
          KEY_STOP:
            play_ctrl.playing <= 1'b0;
          KEY_FWD:
            play_ctrl.reverse <= 1'b0;
          KEY_BWD:
            play_ctrl.reverse <= 1'b1;
          KEY_RESTART:
            play_ctrl.restart <= 1'b1;
          default:
          begin
            // Any other key is ignored
          end
        endcase
      end
    end
  end

endmodule

//--- design/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner #(
  parameter int repeat_cycles = 5_000_000
) (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [2:0] key,
  output logic       speed_up,
  output logic       speed_down,
  output logic       speed_reset
);

  logic [2:0]                       sync_a;
  logic [2:0]                       sync_b;
  logic [2:0]                       pressed;
  logic [$clog2(repeat_cycles)-1:0] rep_cnt;
  logic                             reset_seen;

  // Buttons are active low
  assign pressed = ~sync_b;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sync_a      <= 3'b111;
      sync_b      <= 3'b111;
      rep_cnt     <= '0;
      reset_seen  <= 1'b0;
      speed_up    <= 1'b0;
      speed_down  <= 1'b0;
      speed_reset <= 1'b0;
    end
    else
    begin
      sync_a     <= key;
      sync_b     <= sync_a;
      speed_up   <= 1'b0;
      speed_down <= 1'b0;

      // Shared repeat timer for up and down, up wins if both held
      if (pressed[0] || pressed[1])
      begin
        if (rep_cnt == '0)
        begin
          speed_up   <= pressed[0];
          speed_down <= !pressed[0];
          rep_cnt    <= $bits(rep_cnt)'(repeat_cycles - 1);
        end
        else
        begin
          rep_cnt <= rep_cnt - 1'b1;
        end
      end
      else
      begin
        rep_cnt <= '0;
      end

      // One reset pulse per press
      reset_seen  <= pressed[2];
      speed_reset <= pressed[2] && !reset_seen;
    end
  end

endmodule

//--- design/rate_control.sv
`timescale 1ns/1ps

module rate_control
  import ipod_pkg::*;
(
  input  logic             CLK_50M,
  input  logic             rst_n,
  input  logic             speed_up,
  input  logic             speed_down,
  input  logic             speed_reset,
  output logic [DIV_W-1:0] sample_div,
  output logic             sample_tick
);

  logic [DIV_W-1:0] tick_cnt;
  logic             div_change;

  assign div_change = speed_up || speed_down || speed_reset;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sample_div  <= DEFAULT_SAMPLE_DIV;
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else
    begin
      // Smaller divider means faster playback
      if (speed_reset)
        sample_div <= DEFAULT_SAMPLE_DIV;
      else if (speed_up)
        sample_div <= (sample_div < MIN_SAMPLE_DIV + SPEED_STEP) ?
                      MIN_SAMPLE_DIV : sample_div - SPEED_STEP;
      else if (speed_down)
        sample_div <= (sample_div > MAX_SAMPLE_DIV - SPEED_STEP) ?
                      MAX_SAMPLE_DIV : sample_div + SPEED_STEP;

      // Tick period restarts whenever the rate moves
      if (div_change || tick_cnt == sample_div - 1'b1)
        tick_cnt <= '0;
      else
        tick_cnt <= tick_cnt + 1'b1;

      sample_tick <= !div_change && (tick_cnt == sample_div - 1'b1);
    end
  end

endmodule

//--- design/flash_reader.sv
`timescale 1ns/1ps

module flash_reader
  import ipod_pkg::*;
(
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  flash_req_t              word_req,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  logic [FLASH_DATA_W-1:0] flash_readdata,
  output logic [FLASH_DATA_W-1:0] word_data,
  output logic                    word_valid,
  output logic                    busy
);

  reader_state_e           state;
  logic [FLASH_ADDR_W-1:0] addr_q;

  // Read and address are held while waitrequest is high
  assign flash_read    = (state == REQUEST);
  assign flash_address = addr_q;
  assign busy          = (state != IDLE);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (word_req.read)
            state <= REQUEST;
        end
        REQUEST:
        begin
          // Accepted once waitrequest drops
          if (!flash_waitrequest)
            state <= AWAIT_DATA;
        end
        AWAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= IDLE;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // ==================================================
  // Payload registers
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (state == IDLE && word_req.read)
      addr_q <= word_req.address;
    if (state == AWAIT_DATA && flash_readdatavalid)
      word_data <= flash_readdata;
  end

endmodule

//--- design/sample_sequencer.sv
`timescale 1ns/1ps

module sample_sequencer
  import ipod_pkg::*;
#(
  parameter int song_words = 2**19
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  play_ctrl_t              play_ctrl,
  input  logic                    sample_tick,
  input  logic                    busy,
  input  logic [FLASH_DATA_W-1:0] word_data,
  input  logic                    word_valid,
  output flash_req_t              word_req,
  output logic [SAMPLE_W-1:0]     audio_sample,
  output logic                    audio_valid
);

  logic [FLASH_ADDR_W-1:0] word_addr;
  logic [FLASH_ADDR_W-1:0] last_addr;
  logic                    half_high;
  logic                    waiting;
  logic                    stale;
  logic [SAMPLE_W-1:0]     picked;

  assign last_addr = FLASH_ADDR_W'(song_words - 1);

  // Top byte of the selected 16-bit half
  assign picked = half_high ? word_data[FLASH_DATA_W-1 -: SAMPLE_W]
                            : word_data[FLASH_DATA_W/2-1 -: SAMPLE_W];

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      word_addr   <= '0;
      half_high   <= 1'b0;
      waiting     <= 1'b0;
      stale       <= 1'b0;
      word_req    <= '0;
      audio_valid <= 1'b0;
    end
    else
    begin
      word_req.read <= 1'b0;
      audio_valid   <= 1'b0;

      // Ticks during an outstanding read are dropped
      if (word_valid)
        waiting <= 1'b0;
      if (sample_tick && play_ctrl.playing && !play_ctrl.restart && !busy && !waiting)
      begin
        word_req.read    <= 1'b1;
        word_req.address <= word_addr;
        waiting          <= 1'b1;
      end

      if (play_ctrl.restart)
      begin
        word_addr <= play_ctrl.reverse ? last_addr : '0;
        half_high <= play_ctrl.reverse;
        // Word already in flight belongs to the old position
        stale     <= waiting && !word_valid;
      end
      else if (word_valid)
      begin
        stale <= 1'b0;
        if (!stale)
        begin
          audio_sample <= picked;
          audio_valid  <= 1'b1;
          if (!play_ctrl.reverse)
          begin
            half_high <= !half_high;
            if (half_high)
              word_addr <= (word_addr == last_addr) ? '0 : word_addr + 1'b1;
          end
          else
          begin
            half_high <= !half_high;
            if (!half_high)
              word_addr <= (word_addr == '0) ? last_addr : word_addr - 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- design/speed_display.sv
`timescale 1ns/1ps

module speed_display
  import ipod_pkg::*;
(
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  logic [DIV_W-1:0]       sample_div,
  output seg7_t [HEX_DIGITS-1:0] hex
);

  logic [4*HEX_DIGITS-1:0] div_ext;

  assign div_ext = (4*HEX_DIGITS)'(sample_div);

  // Active-low hex font
  function automatic seg7_t hex_font(input logic [3:0] nibble);
    seg7_t seg;
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      // All segments dark
      hex <= '1;
    end
    else
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
      begin
        hex[i] <= hex_font(div_ext[4*i +: 4]);
      end
    end
  end

endmodule

//--- design/ipod_top.sv
`timescale 1ns/1ps

module ipod_top
  import ipod_pkg::*;
#(
  parameter int song_words    = 2**19,
  parameter int repeat_cycles = 5_000_000
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  key_cmd_e                kbd_ascii,
  input  logic                    kbd_valid,
  input  logic [2:0]              key,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic [FLASH_DATA_W-1:0] flash_readdata,
  input  logic                    flash_readdatavalid,
  output logic [SAMPLE_W-1:0]     audio_sample,
  output logic                    audio_valid,
  output seg7_t [HEX_DIGITS-1:0]  hex
);

  play_ctrl_t              play_ctrl;
  logic                    speed_up;
  logic                    speed_down;
  logic                    speed_reset;
  logic [DIV_W-1:0]        sample_div;
  logic                    sample_tick;
  flash_req_t              word_req;
  logic [FLASH_DATA_W-1:0] word_data;
  logic                    word_valid;
  logic                    busy;

  // ==================================================
  // User controls
  // ==================================================
  key_command_decoder u_keys (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play_ctrl (play_ctrl)
  );

  button_conditioner #(
    .repeat_cycles (repeat_cycles)
  ) u_buttons (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key         (key),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset)
  );

  rate_control u_rate (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_div  (sample_div),
    .sample_tick (sample_tick)
  );

  // ==================================================
  // Sample path
  // ==================================================
  sample_sequencer #(
    .song_words (song_words)
  ) u_seq (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .play_ctrl    (play_ctrl),
    .sample_tick  (sample_tick),
    .busy         (busy),
    .word_data    (word_data),
    .word_valid   (word_valid),
    .word_req     (word_req),
    .audio_sample (audio_sample),
    .audio_valid  (audio_valid)
  );

  flash_reader u_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .word_req            (word_req),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .word_data           (word_data),
    .word_valid          (word_valid),
    .busy                (busy)
  );

  speed_display u_display (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .sample_div (sample_div),
    .hex        (hex)
  );

endmodule

//--- verif/flash_model.sv
`timescale 1ns/1ps

module flash_model
  import ipod_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    read,
  input  logic [FLASH_ADDR_W-1:0] address,
  output logic                    waitrequest,
  output logic [FLASH_DATA_W-1:0] readdata,
  output logic                    readdatavalid
);

  logic [FLASH_DATA_W-1:0] mem [0:depth-1];
  logic [31:0]             lfsr;
  logic [1:0]              wait_left;
  logic [1:0]              delay_left;
  logic                    pending;
  logic [FLASH_ADDR_W-1:0] addr_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // Memory contents, filled before the first clock edge
  initial
  begin : fill
    logic [31:0] word;
    lfsr = 32'hd6de;
    for (int a = 0; a < depth; a++)
    begin
      take_bits(32, word);
      mem[a] = word ^ FLASH_DATA_W'(a);
    end
  end

  // Stall the master for wait_left cycles
  assign waitrequest = read && (wait_left != 2'd0);

  always @(posedge CLK_50M)
  begin : bus
    logic [31:0] r;
    if (!rst_n)
    begin
      wait_left     <= 2'd0;
      pending       <= 1'b0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (read && wait_left != 2'd0)
      begin
        wait_left <= wait_left - 2'd1;
      end
      else if (read)
      begin
        // Accepted, draw the stall for the next read and the data delay
        take_bits(2, r);
        wait_left <= r[1:0];
        take_bits(2, r);
        delay_left <= (r[1:0] % 2'd3) + 2'd1;
        addr_q     <= address;
        pending    <= 1'b1;
      end
      if (pending)
      begin
        if (delay_left == 2'd1)
        begin
          readdata      <= mem[addr_q];
          readdatavalid <= 1'b1;
          pending       <= 1'b0;
        end
        else
        begin
          delay_left <= delay_left - 2'd1;
        end
      end
    end
  end

endmodule

//--- verif/tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod
  import ipod_pkg::*;
#(
  parameter int song_words    = 8,
  parameter int repeat_cycles = 40
) ();

  logic                    CLK_50M;
  logic                    rst_n;
  key_cmd_e                kbd_ascii;
  logic                    kbd_valid;
  logic [2:0]              key;
  logic                    flash_read;
  logic [FLASH_ADDR_W-1:0] flash_address;
  logic                    flash_waitrequest;
  logic [FLASH_DATA_W-1:0] flash_readdata;
  logic                    flash_readdatavalid;
  logic [SAMPLE_W-1:0]     audio_sample;
  logic                    audio_valid;
  seg7_t [HEX_DIGITS-1:0]  hex;

  // Expected player state
  logic [FLASH_ADDR_W-1:0] exp_addr;
  logic                    exp_half;
  logic                    exp_reverse;
  logic [DIV_W-1:0]        exp_div;
  logic                    expect_silent;
  logic                    timed_out;
  int                      samples_seen;
  int                      checks;
  int                      errors;

  // Stalled read seen on the previous cycle
  logic                    stalled_q;
  logic [FLASH_ADDR_W-1:0] stalled_addr;

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  ipod_top #(
    .song_words    (song_words),
    .repeat_cycles (repeat_cycles)
  ) u_dut (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .key                 (key),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid),
    .hex                 (hex)
  );

  flash_model #(
    .depth (song_words)
  ) u_flash (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  // ==================================================
  // Reference functions
  // ==================================================
  // High byte of the selected 16-bit half
  // Half 1 is the upper one
  function automatic logic [SAMPLE_W-1:0] expected_sample(
    input logic [FLASH_ADDR_W-1:0] addr,
    input logic                    half
  );
    logic [FLASH_DATA_W-1:0] word;
    word = u_flash.mem[addr];
    return half ? word[31:24] : word[15:8];
  endfunction

  // Standard active-low hex font
  function automatic seg7_t seg_of(input logic [3:0] nibble);
    seg7_t seg;
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'hA: seg = 7'h08;
      4'hB: seg = 7'h03;
      4'hC: seg = 7'h46;
      4'hD: seg = 7'h21;
      4'hE: seg = 7'h06;
      default: seg = 7'h0E;
    endcase
    return seg;
  endfunction

  // ==================================================
  // Comparing process
  // ==================================================
  always @(negedge CLK_50M)
  begin
    // A stalled read keeps read and address
    if (rst_n && stalled_q)
    begin
      checks = checks + 1;
      if (flash_read !== 1'b1)
      begin
        errors = errors + 1;
        $display("ERROR flash_read: dropped under waitrequest, expected 1 got %h", flash_read);
      end
      if (flash_address !== stalled_addr)
      begin
        errors = errors + 1;
        $display("ERROR flash_address: moved under waitrequest, expected %h got %h",
                 stalled_addr, flash_address);
      end
    end
    stalled_q    = rst_n && flash_read && flash_waitrequest;
    stalled_addr = flash_address;

    if (rst_n && audio_valid)
    begin
      checks = checks + 1;
      if (expect_silent)
      begin
        errors = errors + 1;
        $display("audio_valid pulsed while playback should be stopped, at %0t", $time);
      end
      if (audio_sample !== expected_sample(exp_addr, exp_half))
      begin
        errors = errors + 1;
        $display("ERROR audio_sample: word %h half %0d expected %h got %h",
                 exp_addr, exp_half, expected_sample(exp_addr, exp_half), audio_sample);
      end
      // Step to the next half in the current direction
      if (!exp_reverse && exp_half)
        exp_addr = (exp_addr == song_words - 1) ? '0 : exp_addr + 1'b1;
      else if (exp_reverse && !exp_half)
        exp_addr = (exp_addr == '0) ? FLASH_ADDR_W'(song_words - 1) : exp_addr - 1'b1;
      exp_half = !exp_half;
      samples_seen = samples_seen + 1;
    end
  end

  // ==================================================
  // Stimulus and wait tasks
  // ==================================================
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge CLK_50M);
  endtask

  task automatic send_key(input key_cmd_e cmd);
    @(posedge CLK_50M);
    #2;
    kbd_ascii = cmd;
    kbd_valid = 1'b1;
    @(posedge CLK_50M);
    #2;
    kbd_valid = 1'b0;
  endtask

  task automatic drive_buttons(input logic [2:0] k);
    @(posedge CLK_50M);
    #2;
    key = k;
  endtask

  task automatic wait_samples(input int n);
    int target;
    int cycles;
    if (timed_out)
      return;
    repeat (n)
    begin
      target = samples_seen + 1;
      cycles = 0;
      while (samples_seen < target && cycles < 2 * exp_div + 64)
      begin
        @(posedge CLK_50M);
        cycles = cycles + 1;
      end
      if (samples_seen < target)
      begin
        $display("Timed out waiting for an audio sample at %0t", $time);
        errors = errors + 1;
        timed_out = 1'b1;
        return;
      end
    end
  endtask

  task automatic wait_hex_change();
    seg7_t [HEX_DIGITS-1:0] prev;
    int                     cycles;
    if (timed_out)
      return;
    prev = hex;
    cycles = 0;
    while (hex === prev && cycles < 4 * repeat_cycles + 16)
    begin
      @(negedge CLK_50M);
      cycles = cycles + 1;
    end
    if (hex === prev)
    begin
      $display("Timed out waiting for the display to change at %0t", $time);
      errors = errors + 1;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_hex();
    logic [4*HEX_DIGITS-1:0] div_ext;
    seg7_t                   want;
    if (timed_out)
      return;
    @(negedge CLK_50M);
    div_ext = (4*HEX_DIGITS)'(exp_div);
    for (int i = 0; i < HEX_DIGITS; i++)
    begin
      want = seg_of(div_ext[4*i +: 4]);
      checks = checks + 1;
      if (hex[i] !== want)
      begin
        errors = errors + 1;
        $display("ERROR hex[%0d]: expected %h got %h (divider %h)", i, want, hex[i], exp_div);
      end
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial
  begin
    rst_n         = 1'b0;
    kbd_ascii     = KEY_STOP;
    kbd_valid     = 1'b0;
    key           = 3'b111;
    exp_addr      = '0;
    exp_half      = 1'b0;
    exp_reverse   = 1'b0;
    exp_div       = DEFAULT_SAMPLE_DIV;
    expect_silent = 1'b1;
    timed_out     = 1'b0;
    stalled_q     = 1'b0;
    stalled_addr  = '0;
    samples_seen  = 0;
    checks        = 0;
    errors        = 0;
    repeat (8) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;
    idle_cycles(4);
    check_hex();

    // Speed up until the divider bottoms out, then keep holding
    drive_buttons(3'b110);
    while (exp_div != MIN_SAMPLE_DIV)
    begin
      wait_hex_change();
      exp_div = (exp_div < MIN_SAMPLE_DIV + SPEED_STEP) ? MIN_SAMPLE_DIV
                                                        : exp_div - SPEED_STEP;
      check_hex();
    end
    idle_cycles(3 * repeat_cycles);
    check_hex();
    drive_buttons(3'b111);

    // Slow down to the top of the range
    drive_buttons(3'b101);
    while (exp_div != MAX_SAMPLE_DIV)
    begin
      wait_hex_change();
      exp_div = (exp_div > MAX_SAMPLE_DIV - SPEED_STEP) ? MAX_SAMPLE_DIV
                                                        : exp_div + SPEED_STEP;
      check_hex();
    end
    idle_cycles(3 * repeat_cycles);
    check_hex();
    drive_buttons(3'b111);

    // Rate reset
    drive_buttons(3'b011);
    wait_hex_change();
    exp_div = DEFAULT_SAMPLE_DIV;
    check_hex();
    drive_buttons(3'b111);
    idle_cycles(8);

    // Forward play through the wrap from the last word
    expect_silent = 1'b0;
    send_key(KEY_PLAY);
    wait_samples(20);

    // Pause and allow one tick period to stop
    send_key(KEY_STOP);
    idle_cycles(exp_div);
    expect_silent = 1'b1;
    idle_cycles(3 * exp_div);
    expect_silent = 1'b0;
    send_key(KEY_PLAY);
    wait_samples(4);

    // Reverse through word 0 and back to forward
    send_key(KEY_BWD);
    exp_reverse = 1'b1;
    wait_samples(12);
    send_key(KEY_FWD);
    exp_reverse = 1'b0;
    wait_samples(3);

    // Restart in both directions
    send_key(KEY_RESTART);
    exp_addr = '0;
    exp_half = 1'b0;
    wait_samples(3);
    send_key(KEY_BWD);
    exp_reverse = 1'b1;
    send_key(KEY_RESTART);
    exp_addr = FLASH_ADDR_W'(song_words - 1);
    exp_half = 1'b1;
    wait_samples(3);
    send_key(KEY_STOP);
    idle_cycles(8);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- vlog.f
design/ipod_pkg.sv
design/key_command_decoder.sv
design/button_conditioner.sv
design/rate_control.sv
design/flash_reader.sv
design/sample_sequencer.sv
design/speed_display.sv
design/ipod_top.sv
verif/flash_model.sv
verif/tb_ipod.sv

//--- Bender.yml
package:
  name: ipod_core

sources:
  - files:
      - design/ipod_pkg.sv
      - design/key_command_decoder.sv
      - design/button_conditioner.sv
      - design/rate_control.sv
      - design/flash_reader.sv
      - design/sample_sequencer.sv
      - design/speed_display.sv
      - design/ipod_top.sv
  - target: simulation
    files:
      - verif/flash_model.sv
      - verif/tb_ipod.sv
